// ==== Makefile ====
TOP = tb_bilateral_filter

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== dv/bf_tests.txt ====
# each frame: a line "frame <id> <name>", 5 input rows, then 5 expected output rows
# a row holds six decimal pixels, column 0 first
frame 0 flat
200 200 200 200 200 200
200 200 200 200 200 200
200 200 200 200 200 200
200 200 200 200 200 200
200 200 200 200 200 200
0 0 0 0 0 0
0 200 200 200 200 200
0 200 199 199 199 199
0 200 199 199 199 199
0 200 199 199 199 199
frame 1 vertical step
0 0 0 250 250 250
0 0 0 250 250 250
0 0 0 250 250 250
0 0 0 250 250 250
0 0 0 250 250 250
0 0 0 0 0 0
0 0 0 0 250 250
0 0 0 81 168 249
0 0 0 81 168 249
0 0 0 81 168 249
frame 2 ramps
40 46 51 55 62 66
44 49 53 60 64 70
47 52 58 63 69 73
51 57 61 67 72 77
56 60 66 70 76 81
0 0 0 0 0 0
0 40 46 51 55 62
0 44 49 54 59 64
0 47 52 58 63 68
0 51 56 61 67 72

// ==== dv/tb_bilateral_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bilateral_filter;

    logic                     clk;
    logic                     rst_n;
    logic                     pix_vsync;
    logic                     pix_href;
    logic [bf_pkg::PIX_W-1:0] pix_gray;
    wire                      out_vsync;
    wire                      out_href;
    wire  [bf_pkg::PIX_W-1:0] out_gray;

    int          pix_data [$];      // input pixels of all frames in drive order
    int          exp_data [$];      // expected outputs in the same order
    int          n_frames;
    logic [31:0] lfsr;
    int          exp_gray;          // expected output of the pixel being driven

    // output monitor state
    int   cycle;
    int   in_cycles [$];            // negedge count at which each input was seen
    int   exp_queue [$];
    int   frame_outs;
    int   total_outs;
    int   frames_done;
    logic vsync_d;

    bilateral_filter u_dut
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_vsync (pix_vsync),
        .pix_href  (pix_href),
        .pix_gray  (pix_gray),
        .out_vsync (out_vsync),
        .out_href  (out_href),
        .out_gray  (out_gray)
    );

    always #5 clk = ~clk;

    //----------------------------------------
    // helpers
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            stop_on_error($sformatf("[FAIL] %0t: %s: got %0d, expected %0d",
                                    $time, what, actual, expected));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0])
            nxt = nxt ^ 32'h8020_0003;      // taps 32, 22, 2, 1
        return nxt;
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);        // one step per bit
        end
        return value;
    endfunction

    // a header line "frame <id>" then five input rows and five expected rows
    task automatic load_tests();
        int    fd;
        int    row;
        int    id;
        int    v [6];
        string line;
        row = 0;
        fd  = $fopen("dv/bf_tests.txt", "r");
        if (fd == 0)
            stop_on_error("could not open the test file dv/bf_tests.txt");
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() >= 2 && line.getc(0) != "#")
                begin
                    if ($sscanf(line, "frame %d", id) == 1)
                    begin
                        n_frames++;
                        row = 0;
                    end
                    else if ($sscanf(line, "%d %d %d %d %d %d",
                                     v[0], v[1], v[2], v[3], v[4], v[5]) == 6)
                    begin
                        for (int c = 0; c < 6; c++)
                        begin
                            if (row < bf_pkg::IMG_VDISP)
                                pix_data.push_back(v[c]);
                            else
                                exp_data.push_back(v[c]);
                        end
                        row++;
                    end
                    else
                        stop_on_error($sformatf("unreadable line in the test file: %s", line));
                end
            end
            $fclose(fd);
        end
        if (n_frames == 0 || pix_data.size() != n_frames * 30 || exp_data.size() != n_frames * 30)
            stop_on_error("the test file does not hold whole frames");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic drive_cycle(input logic vsync, input logic href, input int gray, input int exp_val);
        @(posedge clk);
        #1;
        pix_vsync = vsync;
        pix_href  = href;
        pix_gray  = gray[bf_pkg::PIX_W-1:0];
        exp_gray  = exp_val;
    endtask

    //----------------------------------------
    // output monitor sampled on the falling edge
    always @(negedge clk)
    begin
        cycle++;
        if (rst_n && pix_href)
        begin
            in_cycles.push_back(cycle);
            exp_queue.push_back(exp_gray);
        end
        if (out_href)
        begin
            if (in_cycles.size() == 0)
                stop_on_error("the DUT produced an output pixel with no matching input");
            else
            begin
                check_value(cycle - in_cycles.pop_front(), 10, "latency in cycles");
                check_value(out_gray, exp_queue.pop_front(),
                            $sformatf("frame %0d pixel %0d", total_outs / 30, total_outs % 30));
                check_value(out_vsync, 1, "out_vsync while out_href is high");
                frame_outs++;
                total_outs++;
            end
        end
        if (vsync_d && !out_vsync)          // end of an output frame
        begin
            check_value(frame_outs, bf_pkg::IMG_HDISP * bf_pkg::IMG_VDISP, "outputs in frame");
            frame_outs = 0;
            frames_done++;
        end
        vsync_d = out_vsync;
    end

    //----------------------------------------
    initial
    begin
        int gap;
        int idx;
        int wait_cycles;
        clk       = 1'b0;
        rst_n     = 1'b0;
        pix_vsync = 1'b0;
        pix_href  = 1'b0;
        pix_gray  = '0;
        exp_gray  = 0;
        vsync_d   = 1'b0;
        lfsr      = 32'h20d7;
        load_tests();

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet outputs before the first frame
        for (int i = 0; i < 12; i++)
        begin
            @(negedge clk);
            check_value(out_vsync, 0, "out_vsync before the first frame");
            check_value(out_href, 0, "out_href before the first frame");
        end

        for (int f = 0; f < n_frames; f++)
        begin
            for (int r = 0; r < bf_pkg::IMG_VDISP; r++)
            begin
                for (int c = 0; c < bf_pkg::IMG_HDISP; c++)
                begin
                    idx = (f * bf_pkg::IMG_VDISP + r) * bf_pkg::IMG_HDISP + c;
                    drive_cycle(1'b1, 1'b1, pix_data[idx], exp_data[idx]);
                end
                if (r < bf_pkg::IMG_VDISP - 1)
                    gap = 1 + random_bits(2);   // line gap with vsync held high
                else
                    gap = 1 + random_bits(3);   // frame gap with vsync low
                for (int g = 0; g < gap; g++)
                    drive_cycle(r < bf_pkg::IMG_VDISP - 1, 1'b0, 0, 0);
            end
        end

        wait_cycles = 0;
        while (frames_done < n_frames)
        begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 100)
                stop_on_error("timed out waiting for the last frame to leave the DUT");
        end
        check_value(in_cycles.size(), 0, "input pixels still in flight");

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/bf_pkg.sv
rtl/window_gen.sv
rtl/range_weight.sv
rtl/weight_norm.sv
rtl/weighted_sum.sv
rtl/bilateral_filter.sv
dv/tb_bilateral_filter.sv

// ==== rtl/bf_pkg.sv ====
`default_nettype none

package bf_pkg;

    //----------------------------------------
    // image geometry and data widths
    localparam int IMG_HDISP = 6;           // pixels per line
    localparam int IMG_VDISP = 5;           // lines per frame
    localparam int PIX_W     = 8;

    //----------------------------------------
    // range similarity
    localparam int SIM_W          = 10;
    localparam logic [SIM_W-1:0] SIM_MAX = 10'd1023;
    localparam int SIM_STEP_SHIFT = 4;      // diff/16 gives the shift of SIM_MAX

    // fixed spatial kernel, symmetric in both directions
    localparam int KERN_W = 7;
    localparam logic [KERN_W-1:0] KERN_CORNER = 7'd109;
    localparam logic [KERN_W-1:0] KERN_SIDE   = 7'd115;
    localparam logic [KERN_W-1:0] KERN_CENTER = 7'd122;

    //----------------------------------------
    // arithmetic widths
    localparam int WEIGHT_W     = 19;       // three 17-bit products
    localparam int WSUM_W       = 23;
    localparam int FRAC_W       = 10;       // normalized weight is a 0.10 fraction
    localparam int ACC_W        = 18;       // pixel times fraction, summed
    localparam int NORM_LATENCY = 1;

    // flags that travel beside the pixel data
    typedef struct packed {
        logic vsync;
        logic href;
        logic border;                       // centre on row 0 or column 0
    } sync_t;

    // row-major, index 0 top-left, index 4 centre
    typedef logic [8:0][PIX_W-1:0]    window_t;
    typedef logic [8:0][WEIGHT_W-1:0] weights_t;
    typedef logic [8:0][FRAC_W-1:0]   norm_weights_t;

    function automatic logic [KERN_W-1:0] kernel_coef(input int row, input int col);
        logic [KERN_W-1:0] coef;
        if (row == 1 && col == 1)
            coef = KERN_CENTER;
        else if (row == 1 || col == 1)
            coef = KERN_SIDE;
        else
            coef = KERN_CORNER;
        return coef;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/bilateral_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

// 3x3 bilateral filter, 10 cycles from input pixel to output pixel
module bilateral_filter
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          pix_vsync,
    input  wire                          pix_href,
    input  wire [bf_pkg::PIX_W-1:0]      pix_gray,
    output wire                          out_vsync,
    output wire                          out_href,
    output wire [bf_pkg::PIX_W-1:0]      out_gray
);

    wire bf_pkg::sync_t           pix_sync;
    wire bf_pkg::sync_t           gen_sync;             // window stage
    wire bf_pkg::window_t         gen_win;
    wire bf_pkg::sync_t           rw_sync;              // weight stage
    wire bf_pkg::window_t         rw_win;
    wire bf_pkg::weights_t        rw_weights;
    wire [bf_pkg::WSUM_W-1:0]     rw_wsum;
    wire bf_pkg::sync_t           nm_sync;              // normalize stage
    wire bf_pkg::window_t         nm_win;
    wire bf_pkg::norm_weights_t   nm_norm;

    assign pix_sync = {pix_vsync, pix_href, 1'b0};      // border bit filled in later

    //----------------------------------------
    window_gen u_window_gen
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_sync  (pix_sync),
        .in_gray  (pix_gray),
        .win      (gen_win),
        .win_sync (gen_sync)
    );

    range_weight u_range_weight
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .win      (gen_win),
        .in_sync  (gen_sync),
        .weights  (rw_weights),
        .wsum     (rw_wsum),
        .out_win  (rw_win),
        .out_sync (rw_sync)
    );

    weight_norm u_weight_norm
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .weights  (rw_weights),
        .wsum     (rw_wsum),
        .in_win   (rw_win),
        .in_sync  (rw_sync),
        .norm     (nm_norm),
        .out_win  (nm_win),
        .out_sync (nm_sync)
    );

    weighted_sum u_weighted_sum
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .norm      (nm_norm),
        .in_win    (nm_win),
        .in_sync   (nm_sync),
        .out_vsync (out_vsync),
        .out_href  (out_href),
        .out_gray  (out_gray)
    );

endmodule

`default_nettype wire

// ==== rtl/range_weight.sv ====
`timescale 1ns/1ps
`default_nettype none

// range similarity times spatial kernel, four register stages
module range_weight
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire bf_pkg::window_t         win,
    input  wire bf_pkg::sync_t           in_sync,
    output bf_pkg::weights_t             weights,
    output logic [bf_pkg::WSUM_W-1:0]    wsum,
    output bf_pkg::window_t              out_win,
    output bf_pkg::sync_t                out_sync
);

    logic [8:0][bf_pkg::PIX_W-1:0] diff;
    logic [8:0][bf_pkg::SIM_W-1:0] sim;
    logic [bf_pkg::SIM_W+bf_pkg::KERN_W-1:0] prod [3][3][3];   // [row][k][col]
    bf_pkg::weights_t              weight_r;
    logic [bf_pkg::WEIGHT_W+1:0]   part_sum [3];

    bf_pkg::sync_t   sync_pipe [4];
    bf_pkg::window_t win_pipe  [4];

    //----------------------------------------
    // stage 1: absolute difference to the centre
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 9; i++)
        begin
            if (win[i] > win[4])
                diff[i] <= win[i] - win[4];
            else
                diff[i] <= win[4] - win[i];
        end
    end

    // 1023 >> (diff/16), centre always 1023
    always_comb
    begin
        for (int i = 0; i < 9; i++)
            sim[i] = bf_pkg::SIM_MAX >> (diff[i] >> bf_pkg::SIM_STEP_SHIFT);
    end

    //----------------------------------------
    // stage 2: similarity row times kernel column
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 3; i++)
            for (int k = 0; k < 3; k++)
                for (int j = 0; j < 3; j++)
                    prod[i][k][j] <= sim[i*3+k] * bf_pkg::kernel_coef(k, j);
    end

    // stage 3: weight(i,j) = sum over k
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                weight_r[i*3+j] <= prod[i][0][j] + prod[i][1][j] + prod[i][2][j];
    end

    //----------------------------------------
    // stage 4: weight sum, weights held one cycle to line up
    always_comb
    begin
        for (int i = 0; i < 3; i++)
            part_sum[i] = weight_r[i*3] + weight_r[i*3+1] + weight_r[i*3+2];
    end

    always_ff @(posedge clk)
    begin
        wsum    <= part_sum[0] + part_sum[1] + part_sum[2];
        weights <= weight_r;
    end

    // sideband follows the four stages
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < 4; s++)
                sync_pipe[s] <= '0;
        end
        else
        begin
            sync_pipe[0] <= in_sync;
            for (int s = 1; s < 4; s++)
                sync_pipe[s] <= sync_pipe[s-1];
        end
    end

    always_ff @(posedge clk)
    begin
        win_pipe[0] <= win;
        for (int s = 1; s < 4; s++)
            win_pipe[s] <= win_pipe[s-1];
    end

    assign out_sync = sync_pipe[3];
    assign out_win  = win_pipe[3];

endmodule

`default_nettype wire

// ==== rtl/weight_norm.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_norm
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire bf_pkg::weights_t        weights,
    input  wire [bf_pkg::WSUM_W-1:0]     wsum,
    input  wire bf_pkg::window_t         in_win,
    input  wire bf_pkg::sync_t           in_sync,
    output bf_pkg::norm_weights_t        norm,
    output bf_pkg::window_t              out_win,
    output bf_pkg::sync_t                out_sync
);

    logic [bf_pkg::WEIGHT_W+bf_pkg::FRAC_W-1:0] quot [9];

    bf_pkg::norm_weights_t norm_pipe [bf_pkg::NORM_LATENCY];
    bf_pkg::sync_t         sync_pipe [bf_pkg::NORM_LATENCY];
    bf_pkg::window_t       win_pipe  [bf_pkg::NORM_LATENCY];

    // floor division; the centre row always has weight so wsum is never zero
    always_comb
    begin
        for (int i = 0; i < 9; i++)
            quot[i] = {weights[i], {bf_pkg::FRAC_W{1'b0}}} / wsum;
    end

    //----------------------------------------
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 9; i++)
            norm_pipe[0][i] <= quot[i][bf_pkg::FRAC_W-1:0];   // each weight < wsum
        win_pipe[0] <= in_win;
        for (int s = 1; s < bf_pkg::NORM_LATENCY; s++)
        begin
            norm_pipe[s] <= norm_pipe[s-1];
            win_pipe[s]  <= win_pipe[s-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < bf_pkg::NORM_LATENCY; s++)
                sync_pipe[s] <= '0;
        end
        else
        begin
            sync_pipe[0] <= in_sync;
            for (int s = 1; s < bf_pkg::NORM_LATENCY; s++)
                sync_pipe[s] <= sync_pipe[s-1];
        end
    end

    assign norm     = norm_pipe[bf_pkg::NORM_LATENCY-1];
    assign out_win  = win_pipe[bf_pkg::NORM_LATENCY-1];
    assign out_sync = sync_pipe[bf_pkg::NORM_LATENCY-1];

endmodule

`default_nettype wire

// ==== rtl/weighted_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

module weighted_sum
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire bf_pkg::norm_weights_t   norm,
    input  wire bf_pkg::window_t         in_win,
    input  wire bf_pkg::sync_t           in_sync,
    output logic                         out_vsync,
    output logic                         out_href,
    output logic [bf_pkg::PIX_W-1:0]     out_gray
);

    logic [bf_pkg::ACC_W-1:0] prod [9];
    logic [bf_pkg::ACC_W-1:0] part [3];
    logic [bf_pkg::ACC_W-1:0] acc;

    // flags and centre pixel ride along for the first three stages
    bf_pkg::sync_t            sync_pipe   [3];
    logic [bf_pkg::PIX_W-1:0] centre_pipe [3];

    //----------------------------------------
    // products, partial sums, sum
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 9; i++)
            prod[i] <= in_win[i] * norm[i];
        for (int r = 0; r < 3; r++)
            part[r] <= prod[r*3] + prod[r*3+1] + prod[r*3+2];
        acc <= part[0] + part[1] + part[2];

        centre_pipe[0] <= in_win[4];
        centre_pipe[1] <= centre_pipe[0];
        centre_pipe[2] <= centre_pipe[1];
    end

    //----------------------------------------
    // round to nearest, border windows pass the centre through
    always_ff @(posedge clk)
    begin
        if (sync_pipe[2].border)
            out_gray <= centre_pipe[2];
        else
            out_gray <= acc[bf_pkg::ACC_W-1:bf_pkg::FRAC_W] + acc[bf_pkg::FRAC_W-1];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < 3; s++)
                sync_pipe[s] <= '0;
            out_vsync <= 1'b0;
            out_href  <= 1'b0;
        end
        else
        begin
            sync_pipe[0] <= in_sync;
            sync_pipe[1] <= sync_pipe[0];
            sync_pipe[2] <= sync_pipe[1];
            out_vsync    <= sync_pipe[2].vsync;
            out_href     <= sync_pipe[2].href;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/window_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// builds the 3x3 neighbourhood; bottom-right tap is the incoming pixel
module window_gen
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire bf_pkg::sync_t           in_sync,
    input  wire [bf_pkg::PIX_W-1:0]      in_gray,
    output bf_pkg::window_t              win,
    output bf_pkg::sync_t                win_sync
);

    logic [$clog2(bf_pkg::IMG_HDISP + 1)-1:0] col_cnt;   // column of the incoming pixel
    logic [$clog2(bf_pkg::IMG_VDISP + 1)-1:0] row_cnt;   // lines ended in this frame
    logic                                     href_d;

    logic [bf_pkg::PIX_W-1:0] line1 [bf_pkg::IMG_HDISP];  // previous line
    logic [bf_pkg::PIX_W-1:0] line2 [bf_pkg::IMG_HDISP];  // line before that

    // column triplets, [0] top .. [2] bottom
    logic [2:0][bf_pkg::PIX_W-1:0] cur_col;
    logic [2:0][bf_pkg::PIX_W-1:0] col_d1;
    logic [2:0][bf_pkg::PIX_W-1:0] col_d2;

    //----------------------------------------
    // counters
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            href_d   <= 1'b0;
            win_sync <= '0;
        end
        else
        begin
            href_d <= in_sync.href;
            if (in_sync.href)
                col_cnt <= col_cnt + 1'b1;
            else
                col_cnt <= '0;                      // back to column 0 between lines
            if (!in_sync.vsync)
                row_cnt <= '0;
            else if (href_d && !in_sync.href)
                row_cnt <= row_cnt + 1'b1;          // falling href ends a line

            win_sync.vsync  <= in_sync.vsync;
            win_sync.href   <= in_sync.href;
            // centre sits one row up and one column left
            win_sync.border <= (row_cnt < 2) || (col_cnt < 2);
        end
    end

    // rows above the frame read as zero, stale lines from the last frame too
    always_comb
    begin
        cur_col[2] = in_gray;
        cur_col[1] = (row_cnt >= 1) ? line1[col_cnt] : '0;
        cur_col[0] = (row_cnt >= 2) ? line2[col_cnt] : '0;
    end

    //----------------------------------------
    // line buffers and column shift
    always_ff @(posedge clk)
    begin
        if (in_sync.href)
        begin
            line1[col_cnt] <= in_gray;
            line2[col_cnt] <= line1[col_cnt];
            col_d1 <= cur_col;
            col_d2 <= col_d1;
            for (int r = 0; r < 3; r++)
            begin
                win[r*3]   <= (col_cnt >= 2) ? col_d2[r] : '0;   // left of frame is zero
                win[r*3+1] <= (col_cnt >= 1) ? col_d1[r] : '0;
                win[r*3+2] <= cur_col[r];
            end
        end
    end

endmodule

`default_nettype wire
